//--- tb.f
+incdir+verification
src/pcs_rx_pkg.sv
src/block_lock.sv
src/descrambler.sv
src/block_decoder.sv
src/cor_register.sv
src/pcs_rx_top.sv
verification/pcs_rx_tb.sv

//--- Bender.yml
package:
  name: pcs_rx

sources:
  - files:
      - src/pcs_rx_pkg.sv
      - src/block_lock.sv
      - src/descrambler.sv
      - src/block_decoder.sv
      - src/cor_register.sv
      - src/pcs_rx_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/pcs_rx_tb.sv

//--- verification/pcs_rx_tests.svh
// pcs rx directed tests: lock, data path, control decoding, bypass, lock loss, status reads

    // random data blocks, lanes set in bad_mask carry an invalid header
    task automatic send_random(input int count, input logic [N_LANES-1:0] exp_lock,
                               input logic [N_LANES-1:0] bad_mask);
        logic [N_LANES*NB_SH-1:0] hdrs;
        logic [N_LANES*NB_PL-1:0] clear;
        repeat (count)
        begin
            for (int lane = 0; lane < N_LANES; lane++)
            begin
                hdrs[lane*NB_SH +: NB_SH]  = bad_mask[lane] ? 2'b00 : pcs_rx_pkg::SH_DATA;
                clear[lane*NB_PL +: NB_PL] = {$random(seed), $random(seed)};
            end
            send_block(hdrs, clear, exp_lock);
        end
    endtask

    task automatic wait_drained();
        while (exp_data_q.size() != 0)
        begin
            @(posedge i_clock);
            #DRIVE_DELAY;
        end
    endtask

    // rising read edge takes the snapshot and restarts the counters
    task automatic read_counts(input logic hold);
        if (!i_read_err_counts)
        begin
            exp_snapshot = exp_counts;
            exp_counts   = '0;
        end
        i_read_err_counts = 1'b1;
        @(posedge i_clock);
        #DRIVE_DELAY;
        if (!hold)
            i_read_err_counts = 1'b0;
    endtask

    // lane 2 sees a bad header early and locks 11 blocks after the others
    task automatic test_lock_acquisition();
        logic [N_LANES-1:0] lock;
        for (int i = 0; i < LOCK_COUNT + 11; i++)
        begin
            lock = '0;
            if (i >= LOCK_COUNT - 1)
                lock = 4'b1011;
            if (i >= LOCK_COUNT + 10)
                lock = 4'b1111;
            send_random(1, lock, (i == 10) ? 4'b0100 : 4'b0000);
            check_lock("o_lock", o_lock, lock);
        end
        wait_drained();
    endtask

    task automatic test_data_path();
        send_random(40, 4'b1111, 4'b0000);
        wait_drained();
    endtask

    task automatic test_control_blocks();
        logic [N_LANES*NB_SH-1:0] hdrs;
        logic [N_LANES*NB_PL-1:0] clear;
        // idle, unknown type, bad header, data
        hdrs  = {pcs_rx_pkg::SH_DATA, 2'b11, pcs_rx_pkg::SH_CTRL, pcs_rx_pkg::SH_CTRL};
        clear = {{$random(seed), $random(seed)}, {$random(seed), $random(seed)},
                 {56'h0, 8'h2D}, {56'h0, pcs_rx_pkg::BT_IDLE}};
        send_block(hdrs, clear, 4'b1111);
        // idle type behind a bad header still decodes as error
        hdrs  = {pcs_rx_pkg::SH_CTRL, pcs_rx_pkg::SH_CTRL, pcs_rx_pkg::SH_DATA, 2'b00};
        clear = {{56'h0, pcs_rx_pkg::BT_IDLE}, {56'h0, 8'h78},
                 {$random(seed), $random(seed)}, {56'h0, pcs_rx_pkg::BT_IDLE}};
        send_block(hdrs, clear, 4'b1111);
        wait_drained();
    endtask

    task automatic test_bypass();
        i_descrambler_bypass = 1'b1;
        send_random(20, 4'b1111, 4'b0000);
        wait_drained();
        i_descrambler_bypass = 1'b0;
        // both histories took the same raw bits
        send_random(8, 4'b1111, 4'b0000);
        wait_drained();
    endtask

    task automatic test_lock_loss();
        i_window_length    = 12'd32;
        i_sh_invalid_limit = 12'd4;
        // closes the long window so a fresh one starts
        send_random(1, 4'b1111, 4'b0000);
        send_random(1, 4'b1111, 4'b1010);
        send_random(2, 4'b1111, 4'b0010);
        check_lock("o_lock", o_lock, 4'b1111);
        send_random(1, 4'b1101, 4'b0010);
        check_lock("o_lock", o_lock, 4'b1101);
        send_random(4, 4'b1101, 4'b0000);
        wait_drained();
        read_counts(1'b0);
        check_counts("o_err_counts", o_err_counts, exp_snapshot);
    endtask

    task automatic test_clear_on_read();
        send_random(2, 4'b1101, 4'b1001);
        read_counts(1'b1);
        check_counts("o_err_counts", o_err_counts, exp_snapshot);
        // strobe held, so no new snapshot and no clear
        send_random(1, 4'b1101, 4'b0100);
        @(posedge i_clock);
        #DRIVE_DELAY;
        check_counts("o_err_counts", o_err_counts, exp_snapshot);
        i_read_err_counts = 1'b0;
        @(posedge i_clock);
        #DRIVE_DELAY;
        read_counts(1'b0);
        check_counts("o_err_counts", o_err_counts, exp_snapshot);
        i_read_lock = 1'b1;
        @(posedge i_clock);
        #DRIVE_DELAY;
        check_lock("o_lock_snapshot", o_lock_snapshot, 4'b1101);
        i_read_lock = 1'b0;
        wait_drained();
    endtask

//--- verification/pcs_rx_tb.sv
// pcs rx testbench: clock, reset, scrambler model, output checks, watchdog and summary
`timescale 1ns/1ps

module pcs_rx_tb;

    localparam int N_LANES       = 4;
    localparam int LOCK_COUNT    = 64;
    localparam int NB_BLOCK      = pcs_rx_pkg::NB_BLOCK;
    localparam int NB_SH         = pcs_rx_pkg::NB_SH;
    localparam int NB_PL         = pcs_rx_pkg::NB_PAYLOAD;
    localparam int NB_CTRL       = pcs_rx_pkg::NB_CTRL;
    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DELAY   = 10;
    localparam int LATENCY       = 3;
    // blocks sent by all tests, the margin covers drains and reads
    localparam int TEST_BLOCKS   = 157;
    localparam int MARGIN_CYCLES = 200;

    logic                              i_clock;
    logic                              i_reset;
    logic                              i_valid;
    logic [N_LANES*NB_BLOCK-1:0]       i_data;
    logic [pcs_rx_pkg::NB_WINDOW-1:0]  i_window_length;
    logic [pcs_rx_pkg::NB_WINDOW-1:0]  i_sh_invalid_limit;
    logic                              i_descrambler_bypass;
    logic                              i_read_lock;
    logic                              i_read_err_counts;
    logic                              o_valid;
    logic [N_LANES*NB_PL-1:0]          o_data;
    logic [N_LANES*NB_CTRL-1:0]        o_ctrl;
    pcs_rx_pkg::lane_mask_t            o_lock;
    pcs_rx_pkg::lane_mask_t            o_lock_snapshot;
    pcs_rx_pkg::err_bank_t             o_err_counts;

    integer                            seed;
    int unsigned                       cycle;
    int                                error_count;
    logic [pcs_rx_pkg::SCR_TAP_B-1:0]  scr_state [N_LANES];
    pcs_rx_pkg::err_bank_t             exp_counts;
    pcs_rx_pkg::err_bank_t             exp_snapshot;
    logic [N_LANES*NB_PL-1:0]          exp_data_q  [$];
    logic [N_LANES*NB_CTRL-1:0]        exp_ctrl_q  [$];
    int unsigned                       exp_cycle_q [$];

    always #(CLK_PERIOD/2) i_clock = ~i_clock;

    always @(posedge i_clock)
        cycle <= cycle + 1;

    pcs_rx_top
    #(
        .N_LANES              (N_LANES),
        .LOCK_COUNT           (LOCK_COUNT)
    )
    u_dut
    (
        .i_clock              (i_clock),
        .i_reset              (i_reset),
        .i_valid              (i_valid),
        .i_data               (i_data),
        .i_window_length      (i_window_length),
        .i_sh_invalid_limit   (i_sh_invalid_limit),
        .i_descrambler_bypass (i_descrambler_bypass),
        .i_read_lock          (i_read_lock),
        .i_read_err_counts    (i_read_err_counts),
        .o_valid              (o_valid),
        .o_data               (o_data),
        .o_ctrl               (o_ctrl),
        .o_lock               (o_lock),
        .o_lock_snapshot      (o_lock_snapshot),
        .o_err_counts         (o_err_counts)
    );

    task automatic check_data(input string name, input logic [NB_PL-1:0] actual,
                              input logic [NB_PL-1:0] expected);
        if (actual !== expected)
        begin
            $display("** Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
            error_count++;
        end
    endtask

    task automatic check_ctrl(input string name, input logic [NB_CTRL-1:0] actual,
                              input logic [NB_CTRL-1:0] expected);
        if (actual !== expected)
        begin
            $display("** Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
            error_count++;
        end
    endtask

    task automatic check_lock(input string name, input pcs_rx_pkg::lane_mask_t actual,
                              input pcs_rx_pkg::lane_mask_t expected);
        if (actual !== expected)
        begin
            $display("** Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
            error_count++;
        end
    endtask

    task automatic check_counts(input string name, input pcs_rx_pkg::err_bank_t actual,
                                input pcs_rx_pkg::err_bank_t expected);
        if (actual !== expected)
        begin
            $display("** Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
            error_count++;
        end
    endtask

    // x^58+x^39+1 scrambler, state holds the bits put on the line
    task automatic scramble(input int lane, input logic [NB_PL-1:0] clear,
                            input logic bypass, output logic [NB_PL-1:0] line);
        logic [pcs_rx_pkg::SCR_TAP_B-1:0] st;
        st = scr_state[lane];
        for (int b = 0; b < NB_PL; b++)
        begin
            line[b] = bypass ? clear[b] :
                      clear[b] ^ st[pcs_rx_pkg::SCR_TAP_A-1] ^ st[pcs_rx_pkg::SCR_TAP_B-1];
            st = {st[pcs_rx_pkg::SCR_TAP_B-2:0], line[b]};
        end
        scr_state[lane] = st;
    endtask

    // one block on all lanes, exp_lock is the lock vector once this block is taken
    task automatic send_block(input logic [N_LANES*NB_SH-1:0] hdrs,
                              input logic [N_LANES*NB_PL-1:0] clear,
                              input logic [N_LANES-1:0] exp_lock);
        logic [N_LANES*NB_BLOCK-1:0] blocks;
        logic [N_LANES*NB_PL-1:0]    exp_data;
        logic [N_LANES*NB_CTRL-1:0]  exp_ctrl;
        logic [NB_SH-1:0]            hdr;
        logic [NB_PL-1:0]            pl;
        logic [NB_PL-1:0]            line;
        for (int lane = 0; lane < N_LANES; lane++)
        begin
            hdr = hdrs[lane*NB_SH +: NB_SH];
            pl  = clear[lane*NB_PL +: NB_PL];
            scramble(lane, pl, i_descrambler_bypass, line);
            blocks[lane*NB_BLOCK +: NB_BLOCK] = {line, hdr};
            exp_ctrl[lane*NB_CTRL +: NB_CTRL] = '1;
            if (exp_lock[lane] && hdr == pcs_rx_pkg::SH_DATA)
            begin
                exp_data[lane*NB_PL +: NB_PL]     = pl;
                exp_ctrl[lane*NB_CTRL +: NB_CTRL] = '0;
            end
            else if (exp_lock[lane] && hdr == pcs_rx_pkg::SH_CTRL &&
                     pl[7:0] == pcs_rx_pkg::BT_IDLE)
                exp_data[lane*NB_PL +: NB_PL] = {8{pcs_rx_pkg::CH_IDLE}};
            else
                exp_data[lane*NB_PL +: NB_PL] = {8{pcs_rx_pkg::CH_ERROR}};
            if (hdr != pcs_rx_pkg::SH_DATA && hdr != pcs_rx_pkg::SH_CTRL)
                exp_counts[lane] = exp_counts[lane] + 1'b1;
        end
        exp_data_q.push_back(exp_data);
        exp_ctrl_q.push_back(exp_ctrl);
        exp_cycle_q.push_back(cycle);
        i_data  = blocks;
        i_valid = 1'b1;
        @(posedge i_clock);
        #DRIVE_DELAY;
        i_valid = 1'b0;
    endtask

    task automatic compare_output();
        logic [N_LANES*NB_PL-1:0]   data;
        logic [N_LANES*NB_CTRL-1:0] ctrl;
        int unsigned                sent;
        data = exp_data_q.pop_front();
        ctrl = exp_ctrl_q.pop_front();
        sent = exp_cycle_q.pop_front();
        if (cycle - sent != LATENCY)
        begin
            $display("block sent in cycle %0d came out after %0d cycles instead of %0d",
                     sent, cycle - sent, LATENCY);
            error_count++;
        end
        for (int lane = 0; lane < N_LANES; lane++)
        begin
            check_data($sformatf("o_data[%0d]", lane), o_data[lane*NB_PL +: NB_PL],
                       data[lane*NB_PL +: NB_PL]);
            check_ctrl($sformatf("o_ctrl[%0d]", lane), o_ctrl[lane*NB_CTRL +: NB_CTRL],
                       ctrl[lane*NB_CTRL +: NB_CTRL]);
        end
    endtask

    // outputs settle after the rising edge
    always @(negedge i_clock)
    begin
        if (!i_reset && o_valid)
        begin
            if (exp_data_q.size() == 0)
            begin
                $display("o_valid was high with no block expected at %0t", $time);
                error_count++;
            end
            else
                compare_output();
        end
    end

    `include "pcs_rx_tests.svh"

    initial
    begin
        #((TEST_BLOCKS + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout, the tests did not finish in time with %0d errors", error_count);
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        seed                 = 32'h6588;
        cycle                = 0;
        error_count          = 0;
        i_clock              = 1'b0;
        i_reset              = 1'b1;
        i_valid              = 1'b0;
        i_data               = '0;
        i_window_length      = 12'hFFF;
        i_sh_invalid_limit   = 12'd4;
        i_descrambler_bypass = 1'b0;
        i_read_lock          = 1'b0;
        i_read_err_counts    = 1'b0;
        exp_counts           = '0;
        exp_snapshot         = '0;
        for (int lane = 0; lane < N_LANES; lane++)
            scr_state[lane] = '0;
        repeat (5) @(posedge i_clock);
        #DRIVE_DELAY;
        i_reset = 1'b0;
        check_lock("o_lock", o_lock, '0);
        check_lock("o_lock_snapshot", o_lock_snapshot, '0);
        check_counts("o_err_counts", o_err_counts, '0);

        test_lock_acquisition();
        test_data_path();
        test_control_blocks();
        test_bypass();
        test_lock_loss();
        test_clear_on_read();

        if (exp_data_q.size() != 0)
        begin
            $display("%0d expected blocks never came out", exp_data_q.size());
            error_count++;
        end
        $display("tests finished with %0d errors", error_count);
        if (error_count == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- src/pcs_rx_top.sv
// pcs rx top: block lock, descrambler and block decoder with clear-on-read status registers
`timescale 1ns/1ps

module pcs_rx_top
#(
    parameter int N_LANES    = 4,
    parameter int LOCK_COUNT = 64
)
(
    input  logic                                         i_clock,
    input  logic                                         i_reset,
    input  logic                                         i_valid,
    input  logic [N_LANES*pcs_rx_pkg::NB_BLOCK-1:0]      i_data,
    input  logic [pcs_rx_pkg::NB_WINDOW-1:0]             i_window_length,
    input  logic [pcs_rx_pkg::NB_WINDOW-1:0]             i_sh_invalid_limit,
    input  logic                                         i_descrambler_bypass,
    input  logic                                         i_read_lock,
    input  logic                                         i_read_err_counts,
    output logic                                         o_valid,
    output logic [N_LANES*pcs_rx_pkg::NB_PAYLOAD-1:0]    o_data,
    output logic [N_LANES*pcs_rx_pkg::NB_CTRL-1:0]       o_ctrl,
    output pcs_rx_pkg::lane_mask_t                       o_lock,
    output pcs_rx_pkg::lane_mask_t                       o_lock_snapshot,
    output pcs_rx_pkg::err_bank_t                        o_err_counts
);

    // block lock to descrambler
    logic                                    lock_valid;
    logic [N_LANES*pcs_rx_pkg::NB_BLOCK-1:0] lock_data;
    logic [N_LANES-1:0]                      lock_sh_ok;

    // descrambler to decoder
    logic                                    dscr_valid;
    logic [N_LANES*pcs_rx_pkg::NB_BLOCK-1:0] dscr_data;
    logic [N_LANES-1:0]                      dscr_sh_ok;

    // status
    pcs_rx_pkg::lane_mask_t                  lane_lock;
    pcs_rx_pkg::err_bank_t                   err_counts;
    logic                                    clear_counts;

    block_lock
    #(
        .N_LANES            (N_LANES),
        .LOCK_COUNT         (LOCK_COUNT)
    )
    u_block_lock
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_valid            (i_valid),
        .i_data             (i_data),
        .i_window_length    (i_window_length),
        .i_sh_invalid_limit (i_sh_invalid_limit),
        .i_clear_counts     (clear_counts),
        .o_valid            (lock_valid),
        .o_data             (lock_data),
        .o_sh_ok            (lock_sh_ok),
        .o_lock             (lane_lock),
        .o_err_counts       (err_counts)
    );

    descrambler
    #(
        .N_LANES            (N_LANES)
    )
    u_descrambler
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_valid            (lock_valid),
        .i_data             (lock_data),
        .i_sh_ok            (lock_sh_ok),
        .i_bypass           (i_descrambler_bypass),
        .o_valid            (dscr_valid),
        .o_data             (dscr_data),
        .o_sh_ok            (dscr_sh_ok)
    );

    block_decoder
    #(
        .N_LANES            (N_LANES)
    )
    u_block_decoder
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_valid            (dscr_valid),
        .i_data             (dscr_data),
        .i_sh_ok            (dscr_sh_ok),
        .i_lock             (lane_lock),
        .o_valid            (o_valid),
        .o_data             (o_data),
        .o_ctrl             (o_ctrl)
    );

    cor_register
    #(
        .T                  (pcs_rx_pkg::lane_mask_t)
    )
    u_cor_lock
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_value            (lane_lock),
        .i_read             (i_read_lock),
        .o_value            (o_lock_snapshot),
        .o_clear            ()
    );

    // the read edge also restarts the invalid-header counters
    cor_register
    #(
        .T                  (pcs_rx_pkg::err_bank_t)
    )
    u_cor_err_counts
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_value            (err_counts),
        .i_read             (i_read_err_counts),
        .o_value            (o_err_counts),
        .o_clear            (clear_counts)
    );

    assign o_lock = lane_lock;

endmodule

//--- src/cor_register.sv
// clear-on-read register: snapshots a status value on the rising edge of a read strobe
`timescale 1ns/1ps

module cor_register
#(
    parameter type T = logic
)
(
    input  logic i_clock,
    input  logic i_reset,
    input  T     i_value,
    input  logic i_read,
    output T     o_value,
    output logic o_clear
);

    logic read_d;
    logic read_edge;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            read_d <= 1'b0;
        else
            read_d <= i_read;
    end

    // a held strobe gives only one edge
    assign read_edge = i_read & ~read_d;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_value <= '0;
        else if (read_edge)
            o_value <= i_value;
    end

    // source clears in the same cycle the snapshot is taken
    assign o_clear = read_edge;

endmodule

//--- src/block_decoder.sv
// block decoder: turns 66-bit blocks into 64 data bits and 8 control flags per lane
`timescale 1ns/1ps

module block_decoder
#(
    parameter int N_LANES = 4
)
(
    input  logic                                         i_clock,
    input  logic                                         i_reset,
    input  logic                                         i_valid,
    input  logic [N_LANES*pcs_rx_pkg::NB_BLOCK-1:0]      i_data,
    input  logic [N_LANES-1:0]                           i_sh_ok,
    input  pcs_rx_pkg::lane_mask_t                       i_lock,
    output logic                                         o_valid,
    output logic [N_LANES*pcs_rx_pkg::NB_PAYLOAD-1:0]    o_data,
    output logic [N_LANES*pcs_rx_pkg::NB_CTRL-1:0]       o_ctrl
);

    localparam int NB_PL = pcs_rx_pkg::NB_PAYLOAD;

    pcs_rx_pkg::lane_mask_t           lock_d;
    logic [NB_PL-1:0]                 dec_data [N_LANES];
    logic [pcs_rx_pkg::NB_CTRL-1:0]   dec_ctrl [N_LANES];

    always_comb
    begin : p_decode
        logic [pcs_rx_pkg::NB_SH-1:0] header;
        logic [NB_PL-1:0]             payload;
        for (int lane = 0; lane < N_LANES; lane++)
        begin
            header  = i_data[lane*pcs_rx_pkg::NB_BLOCK +: pcs_rx_pkg::NB_SH];
            payload = i_data[lane*pcs_rx_pkg::NB_BLOCK + pcs_rx_pkg::NB_SH +: NB_PL];
            if (lock_d[lane] && i_sh_ok[lane] && header == pcs_rx_pkg::SH_DATA)
            begin
                dec_data[lane] = payload;
                dec_ctrl[lane] = '0;
            end
            else if (lock_d[lane] && i_sh_ok[lane] && header == pcs_rx_pkg::SH_CTRL &&
                     payload[pcs_rx_pkg::NB_BLOCK_TYPE-1:0] == pcs_rx_pkg::BT_IDLE)
            begin
                dec_data[lane] = {8{pcs_rx_pkg::CH_IDLE}};
                dec_ctrl[lane] = '1;
            end
            else
            begin
                // unknown type, bad header or lane out of lock
                dec_data[lane] = {8{pcs_rx_pkg::CH_ERROR}};
                dec_ctrl[lane] = '1;
            end
        end
    end

    // lock lags one stage behind the block it belongs to
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            lock_d  <= '0;
            o_valid <= 1'b0;
        end
        else
        begin
            lock_d  <= i_lock;
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            for (int lane = 0; lane < N_LANES; lane++)
            begin
                o_data[lane*NB_PL +: NB_PL] <= dec_data[lane];
                o_ctrl[lane*pcs_rx_pkg::NB_CTRL +: pcs_rx_pkg::NB_CTRL] <= dec_ctrl[lane];
            end
        end
    end

endmodule

//--- src/descrambler.sv
// descrambler: per-lane self-synchronizing x^58+x^39+1 payload descrambler with bypass
`timescale 1ns/1ps

module descrambler
#(
    parameter int N_LANES = 4
)
(
    input  logic                                         i_clock,
    input  logic                                         i_reset,
    input  logic                                         i_valid,
    input  logic [N_LANES*pcs_rx_pkg::NB_BLOCK-1:0]      i_data,
    input  logic [N_LANES-1:0]                           i_sh_ok,
    input  logic                                         i_bypass,
    output logic                                         o_valid,
    output logic [N_LANES*pcs_rx_pkg::NB_BLOCK-1:0]      o_data,
    output logic [N_LANES-1:0]                           o_sh_ok
);

    localparam int NB_HIST = pcs_rx_pkg::SCR_TAP_B;
    localparam int NB_PL   = pcs_rx_pkg::NB_PAYLOAD;

    logic [NB_HIST-1:0] hist          [N_LANES];
    logic [NB_HIST-1:0] next_hist     [N_LANES];
    logic [NB_PL-1:0]   clear_payload [N_LANES];

    // bit-serial from payload bit 0, history holds received scrambled bits
    always_comb
    begin : p_descramble
        logic [NB_HIST-1:0] shift;
        logic               scr_bit;
        for (int lane = 0; lane < N_LANES; lane++)
        begin
            shift = hist[lane];
            for (int bit_idx = 0; bit_idx < NB_PL; bit_idx++)
            begin
                scr_bit = i_data[lane*pcs_rx_pkg::NB_BLOCK + pcs_rx_pkg::NB_SH + bit_idx];
                clear_payload[lane][bit_idx] = scr_bit ^ shift[pcs_rx_pkg::SCR_TAP_A-1]
                                                       ^ shift[pcs_rx_pkg::SCR_TAP_B-1];
                shift = {shift[NB_HIST-2:0], scr_bit};
            end
            next_hist[lane] = shift;
        end
    end

    // history advances in bypass too
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_valid <= 1'b0;
            for (int lane = 0; lane < N_LANES; lane++)
                hist[lane] <= '0;
        end
        else
        begin
            o_valid <= i_valid;
            if (i_valid)
            begin
                for (int lane = 0; lane < N_LANES; lane++)
                    hist[lane] <= next_hist[lane];
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            o_sh_ok <= i_sh_ok;
            for (int lane = 0; lane < N_LANES; lane++)
            begin
                o_data[lane*pcs_rx_pkg::NB_BLOCK +: pcs_rx_pkg::NB_SH] <=
                    i_data[lane*pcs_rx_pkg::NB_BLOCK +: pcs_rx_pkg::NB_SH];
                o_data[lane*pcs_rx_pkg::NB_BLOCK + pcs_rx_pkg::NB_SH +: NB_PL] <= i_bypass ?
                    i_data[lane*pcs_rx_pkg::NB_BLOCK + pcs_rx_pkg::NB_SH +: NB_PL] :
                    clear_payload[lane];
            end
        end
    end

endmodule

//--- src/block_lock.sv
// block lock: per-lane sync header check, window-based lock FSM and invalid-header counters
`timescale 1ns/1ps

module block_lock
#(
    parameter int N_LANES    = 4,
    parameter int LOCK_COUNT = 64
)
(
    input  logic                                         i_clock,
    input  logic                                         i_reset,
    input  logic                                         i_valid,
    input  logic [N_LANES*pcs_rx_pkg::NB_BLOCK-1:0]      i_data,
    input  logic [pcs_rx_pkg::NB_WINDOW-1:0]             i_window_length,
    input  logic [pcs_rx_pkg::NB_WINDOW-1:0]             i_sh_invalid_limit,
    input  logic                                         i_clear_counts,
    output logic                                         o_valid,
    output logic [N_LANES*pcs_rx_pkg::NB_BLOCK-1:0]      o_data,
    output logic [N_LANES-1:0]                           o_sh_ok,
    output pcs_rx_pkg::lane_mask_t                       o_lock,
    output pcs_rx_pkg::err_bank_t                        o_err_counts
);

    localparam int NB_GOOD = $clog2(LOCK_COUNT + 1);

    logic [NB_GOOD-1:0]               good_cnt [N_LANES];
    logic [pcs_rx_pkg::NB_WINDOW-1:0] win_cnt  [N_LANES];
    logic [pcs_rx_pkg::NB_WINDOW-1:0] inv_cnt  [N_LANES];
    logic [N_LANES-1:0]               sh_ok;
    logic [N_LANES-1:0]               win_done;
    logic [N_LANES-1:0]               inv_limit;
    pcs_rx_pkg::lane_mask_t           lock;
    pcs_rx_pkg::err_bank_t            err_counts;

    always_comb
    begin
        for (int lane = 0; lane < N_LANES; lane++)
        begin
            sh_ok[lane] = (i_data[lane*pcs_rx_pkg::NB_BLOCK +: pcs_rx_pkg::NB_SH]
                           == pcs_rx_pkg::SH_DATA) ||
                          (i_data[lane*pcs_rx_pkg::NB_BLOCK +: pcs_rx_pkg::NB_SH]
                           == pcs_rx_pkg::SH_CTRL);
            // one bit wider so the +1 cannot wrap
            win_done[lane]  = ({1'b0, win_cnt[lane]} + 1'b1) >= {1'b0, i_window_length};
            inv_limit[lane] = ({1'b0, inv_cnt[lane]} + 1'b1) >= {1'b0, i_sh_invalid_limit};
        end
    end

    // lock FSM, one bit of state per lane plus its counters
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            lock <= '0;
            for (int lane = 0; lane < N_LANES; lane++)
            begin
                good_cnt[lane] <= '0;
                win_cnt[lane]  <= '0;
                inv_cnt[lane]  <= '0;
            end
        end
        else if (i_valid)
        begin
            for (int lane = 0; lane < N_LANES; lane++)
            begin
                if (!lock[lane])
                begin
                    win_cnt[lane] <= '0;
                    inv_cnt[lane] <= '0;
                    if (!sh_ok[lane])
                        good_cnt[lane] <= '0;
                    else if (good_cnt[lane] == NB_GOOD'(LOCK_COUNT - 1))
                    begin
                        good_cnt[lane] <= '0;
                        lock[lane]     <= 1'b1;
                    end
                    else
                        good_cnt[lane] <= good_cnt[lane] + 1'b1;
                end
                else if (!sh_ok[lane] && inv_limit[lane])
                begin
                    lock[lane]     <= 1'b0;
                    good_cnt[lane] <= '0;
                    win_cnt[lane]  <= '0;
                    inv_cnt[lane]  <= '0;
                end
                else if (win_done[lane])
                begin
                    win_cnt[lane] <= '0;
                    inv_cnt[lane] <= '0;
                end
                else
                begin
                    win_cnt[lane] <= win_cnt[lane] + 1'b1;
                    if (!sh_ok[lane])
                        inv_cnt[lane] <= inv_cnt[lane] + 1'b1;
                end
            end
        end
    end

    // saturating invalid-header counters, clear wins over a count
    always_ff @(posedge i_clock)
    begin
        if (i_reset || i_clear_counts)
            err_counts <= '0;
        else if (i_valid)
        begin
            for (int lane = 0; lane < N_LANES; lane++)
            begin
                if (!sh_ok[lane] && !(&err_counts[lane]))
                    err_counts[lane] <= err_counts[lane] + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_valid <= 1'b0;
        else
            o_valid <= i_valid;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            o_data  <= i_data;
            o_sh_ok <= sh_ok;
        end
    end

    assign o_lock       = lock;
    assign o_err_counts = err_counts;

endmodule

//--- src/pcs_rx_pkg.sv
// pcs rx package: block widths, header and block-type codes, scrambler taps, status types
package pcs_rx_pkg;

    // coded block layout, header in the low bits
    localparam int NB_BLOCK      = 66;
    localparam int NB_SH         = 2;
    localparam int NB_PAYLOAD    = 64;
    localparam int NB_CTRL       = 8;

    // sync header values
    localparam logic [NB_SH-1:0] SH_DATA = 2'b01;
    localparam logic [NB_SH-1:0] SH_CTRL = 2'b10;

    // block type is the first payload byte
    localparam int NB_BLOCK_TYPE = 8;
    localparam logic [NB_BLOCK_TYPE-1:0] BT_IDLE = 8'h1E;

    // decoded characters
    localparam logic [7:0] CH_IDLE  = 8'h07;
    localparam logic [7:0] CH_ERROR = 8'hFE;

    // x^58 + x^39 + 1
    localparam int SCR_TAP_A     = 39;
    localparam int SCR_TAP_B     = 58;

    // window length and invalid-limit inputs
    localparam int NB_WINDOW     = 12;

    // per-lane saturating invalid-header counter
    localparam int NB_ERR_COUNT  = 16;

    // lane vectors are sized for the largest build
    localparam int MAX_LANES     = 8;

    // status types
    typedef logic [MAX_LANES-1:0] lane_mask_t;

    typedef logic [NB_ERR_COUNT-1:0] err_count_t;

    // unused lanes read back as zero
    typedef err_count_t [MAX_LANES-1:0] err_bank_t;

endpackage
